/* common/bp_config.svh */
// ==========================================================
// Sizing for the fetch-stage branch predictor
// Include wherever table or address widths are needed
// ==========================================================

`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// ==========================================================
// Address path
// ==========================================================

// PC, target and instruction word width
`define BP_XLEN 32

// ==========================================================
// Direction predictor
// ==========================================================

// Global history length in resolved branches
`define BP_GHR_BITS 8
// 2-bit counters, power of two, index width is its log2
`define BP_PHT_ENTRIES 256

// ==========================================================
// Target caches
// ==========================================================

// Taken conditional branch targets
`define BP_BTB_ENTRIES 64
// JALR targets
`define BP_IBTC_ENTRIES 32

`endif

/* common/bp_pkg.sv */
// ==========================================================
// Shared types of the branch predictor
// Compile ahead of every predictor module
// ==========================================================

`include "bp_config.svh"

package bp_pkg;

  // PC or target address
  typedef logic [`BP_XLEN-1:0] xaddr_t;

  // RV32 opcodes of the control transfers
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // Kind of control transfer
  typedef enum logic [1:0] {
    CTI_NONE   = 2'd0,
    CTI_BRANCH = 2'd1,
    CTI_JAL    = 2'd2,
    CTI_JALR   = 2'd3
  } cti_kind_e;

  // Origin of a prediction
  typedef enum logic [1:0] {
    SRC_SEQ    = 2'd0,
    SRC_JUMP   = 2'd1,
    SRC_BRANCH = 2'd2
  } pred_src_e;

  // Fetch stage input, sampled every cycle
  typedef struct packed {
    logic                valid;
    xaddr_t              pc;
    logic [`BP_XLEN-1:0] instr;
  } fetch_t;

  // Execute stage report of a resolved transfer
  typedef struct packed {
    logic      valid;
    cti_kind_e kind;
    xaddr_t    pc;
    logic      taken;
    xaddr_t    target;
  } resolve_t;

  // Decoded fetch, valid already qualified by the stall
  typedef struct packed {
    logic      valid;
    cti_kind_e kind;
    xaddr_t    pc;
    xaddr_t    imm;
  } fetch_dec_t;

  // Target cache write port
  typedef struct packed {
    logic   en;
    xaddr_t pc;
    xaddr_t target;
  } cache_wr_t;

  // Prediction towards the fetch PC mux
  typedef struct packed {
    xaddr_t    pc;
    logic      taken;
    pred_src_e src;
  } pred_t;

endpackage

/* rtl/bp_decode.sv */
// ==========================================================
// Instruction classification and event qualification
// Feeds the lookup and training sides of the predictor
// ==========================================================
`timescale 1ns/1ps

module bp_decode (
  input  bp_pkg::fetch_t     fetch_i,
  input  bp_pkg::resolve_t   resolve_i,
  input  logic               stall_i,
  output bp_pkg::fetch_dec_t fetch_dec_o,
  output logic               pht_train_en_o,
  output bp_pkg::cache_wr_t  btb_wr_o,
  output bp_pkg::cache_wr_t  ibtc_wr_o
);
  import bp_pkg::*;

  logic [6:0] opcode;
  cti_kind_e  fetch_kind;
  xaddr_t     imm;
  logic       res_ok;

  assign opcode = fetch_i.instr[6:0];

  // Opcode to transfer kind, immediate per format
  always_comb begin
    fetch_kind = CTI_NONE;
    imm        = '0;
    case (opcode)
      OPC_BRANCH: begin
        fetch_kind = CTI_BRANCH;
        // B-type, bit 0 always zero
        imm = {{20{fetch_i.instr[31]}}, fetch_i.instr[7], fetch_i.instr[30:25],
               fetch_i.instr[11:8], 1'b0};
      end
      OPC_JAL: begin
        fetch_kind = CTI_JAL;
        // J-type, 21-bit signed offset
        imm = {{12{fetch_i.instr[31]}}, fetch_i.instr[19:12], fetch_i.instr[20],
               fetch_i.instr[30:21], 1'b0};
      end
      OPC_JALR: begin
        fetch_kind = CTI_JALR;
        // I-type, only informative since the target comes from the IBTC
        imm = {{20{fetch_i.instr[31]}}, fetch_i.instr[31:20]};
      end
      default: begin
        fetch_kind = CTI_NONE;
      end
    endcase
  end

  // Fetch side, stall drops the request
  assign fetch_dec_o.valid = fetch_i.valid & ~stall_i;
  assign fetch_dec_o.kind  = fetch_kind;
  assign fetch_dec_o.pc    = fetch_i.pc;
  assign fetch_dec_o.imm   = imm;

  // Resolve is lost while stalled, execute holds it
  assign res_ok = resolve_i.valid & ~stall_i;

  // Only conditional branches train direction and history
  assign pht_train_en_o = res_ok && (resolve_i.kind == CTI_BRANCH);

  // BTB keeps taken branch targets only
  assign btb_wr_o.en     = pht_train_en_o & resolve_i.taken;
  assign btb_wr_o.pc     = resolve_i.pc;
  assign btb_wr_o.target = resolve_i.target;

  // Every resolved JALR refreshes its IBTC entry
  assign ibtc_wr_o.en     = res_ok && (resolve_i.kind == CTI_JALR);
  assign ibtc_wr_o.pc     = resolve_i.pc;
  assign ibtc_wr_o.target = resolve_i.target;

endmodule

/* predictor/gshare_pht.sv */
// ==========================================================
// Gshare direction predictor with global history
// Combinational lookup, training at the clock edge
// ==========================================================
`timescale 1ns/1ps
`include "bp_config.svh"

module gshare_pht (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  bp_pkg::xaddr_t lookup_pc_i,
  input  logic           train_en_i,
  input  bp_pkg::xaddr_t train_pc_i,
  input  logic           train_taken_i,
  output logic           taken_o
);

  localparam int IDX_W = $clog2(`BP_PHT_ENTRIES);
  localparam int GHR_W = `BP_GHR_BITS;

  // ==========================================================
  // State
  // ==========================================================

  // Newest outcome in bit 0
  logic [GHR_W-1:0] ghr_q;
  // 2-bit saturating counters, MSB is the direction
  logic [1:0]       pht_q [`BP_PHT_ENTRIES];

  logic [IDX_W-1:0] hist_fold;
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;
  logic [1:0]       wr_ctr;
  logic [1:0]       ctr_next;

  // ==========================================================
  // Index and lookup
  // ==========================================================

  // History sized to the index width
  assign hist_fold = IDX_W'(ghr_q);

  // PC word index XOR history, same for both sides
  assign rd_idx = lookup_pc_i[IDX_W+1:2] ^ hist_fold;
  // Pre-shift history, matches the lookup that made the guess
  assign wr_idx = train_pc_i[IDX_W+1:2] ^ hist_fold;

  assign taken_o = pht_q[rd_idx][1];

  // ==========================================================
  // Training
  // ==========================================================

  // Step by one, stick at 0 and 3
  always_comb begin
    wr_ctr   = pht_q[wr_idx];
    ctr_next = wr_ctr;
    if (train_taken_i) begin
      if (wr_ctr != 2'b11) ctr_next = wr_ctr + 2'd1;
    end else begin
      if (wr_ctr != 2'b00) ctr_next = wr_ctr - 2'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ghr_q <= '0;
      // Weakly not-taken
      for (int i = 0; i < `BP_PHT_ENTRIES; i++) begin
        pht_q[i] <= 2'b01;
      end
    end else if (train_en_i) begin
      pht_q[wr_idx] <= ctr_next;
      ghr_q         <= {ghr_q[GHR_W-2:0], train_taken_i};
    end
  end

  // Decode must hold training off until reset is released
  a_no_train_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !train_en_i)
    else $error("gshare_pht: training request during reset");

endmodule

/* predictor/target_cache.sv */
// ==========================================================
// Direct-mapped tagged target table
// Used as the BTB and as the indirect target cache
// ==========================================================
`timescale 1ns/1ps
`include "bp_config.svh"

module target_cache #(
  parameter int ENTRIES = 64
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  bp_pkg::xaddr_t    lookup_pc_i,
  input  bp_pkg::cache_wr_t wr_i,
  output logic              hit_o,
  output bp_pkg::xaddr_t    target_o
);

  // Index from PC bit 2, tag is everything above it
  localparam int IDX_W = $clog2(ENTRIES);
  localparam int TAG_W = `BP_XLEN - IDX_W - 2;

  logic                valid_q  [ENTRIES];
  logic [TAG_W-1:0]    tag_q    [ENTRIES];
  logic [`BP_XLEN-1:0] target_q [ENTRIES];

  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] rd_tag;
  logic [TAG_W-1:0] wr_tag;

  // ==========================================================
  // Lookup
  // ==========================================================

  assign rd_idx = lookup_pc_i[IDX_W+1:2];
  assign rd_tag = lookup_pc_i[`BP_XLEN-1:IDX_W+2];

  // Old contents are seen when a write hits the same entry
  assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign target_o = target_q[rd_idx];

  // ==========================================================
  // Update
  // ==========================================================

  assign wr_idx = wr_i.pc[IDX_W+1:2];
  assign wr_tag = wr_i.pc[`BP_XLEN-1:IDX_W+2];

  // Valid bits
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < ENTRIES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (wr_i.en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Tag and target, replaced on every write
  always_ff @(posedge clk_i) begin
    if (wr_i.en) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= wr_i.target;
    end
  end

  // An X enable would corrupt a random entry
  a_wr_en_known: assert property (@(posedge clk_i) disable iff (!rst_ni) !$isunknown(wr_i.en))
    else $error("target_cache: write enable unknown");

endmodule

/* rtl/predict_select.sv */
// ==========================================================
// Prediction priority and next-PC formation
// Purely combinational, same cycle as the fetch
// ==========================================================
`timescale 1ns/1ps

module predict_select (
  input  bp_pkg::fetch_dec_t fetch_dec_i,
  input  logic               pht_taken_i,
  input  logic               btb_hit_i,
  input  bp_pkg::xaddr_t     btb_target_i,
  input  logic               ibtc_hit_i,
  input  bp_pkg::xaddr_t     ibtc_target_i,
  output bp_pkg::pred_t      pred_o
);
  import bp_pkg::*;

  xaddr_t pc_seq;
  xaddr_t pc_rel;

  assign pc_seq = fetch_dec_i.pc + xaddr_t'(4);
  // PC-relative target, meaningful for JAL
  assign pc_rel = fetch_dec_i.pc + fetch_dec_i.imm;

  // JAL, then JALR on IBTC hit, then taken branch on BTB hit
  always_comb begin
    pred_o.pc    = pc_seq;
    pred_o.taken = 1'b0;
    pred_o.src   = SRC_SEQ;
    if (fetch_dec_i.valid) begin
      if (fetch_dec_i.kind == CTI_JAL) begin
        pred_o.pc    = pc_rel;
        pred_o.taken = 1'b1;
        pred_o.src   = SRC_JUMP;
      end else if (fetch_dec_i.kind == CTI_JALR && ibtc_hit_i) begin
        pred_o.pc    = ibtc_target_i;
        pred_o.taken = 1'b1;
        pred_o.src   = SRC_JUMP;
      end else if (fetch_dec_i.kind == CTI_BRANCH && pht_taken_i && btb_hit_i) begin
        // Taken guess needs a known target
        pred_o.pc    = btb_target_i;
        pred_o.taken = 1'b1;
        pred_o.src   = SRC_BRANCH;
      end
    end
  end

endmodule

/* rtl/bp_top.sv */
// ==========================================================
// Fetch-stage branch predictor top level
// Decode, gshare, BTB, IBTC and next-PC select
// ==========================================================
`timescale 1ns/1ps
`include "bp_config.svh"

module bp_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             stall_i,
  input  bp_pkg::fetch_t   fetch_i,
  input  bp_pkg::resolve_t resolve_i,
  output bp_pkg::pred_t    pred_o
);
  import bp_pkg::*;

  fetch_dec_t fetch_dec;
  logic       pht_train_en;
  cache_wr_t  btb_wr;
  cache_wr_t  ibtc_wr;
  logic       pht_taken;
  logic       btb_hit;
  xaddr_t     btb_target;
  logic       ibtc_hit;
  xaddr_t     ibtc_target;

  // Stall is applied here only
  bp_decode u_decode (
    .fetch_i        (fetch_i),
    .resolve_i      (resolve_i),
    .stall_i        (stall_i),
    .fetch_dec_o    (fetch_dec),
    .pht_train_en_o (pht_train_en),
    .btb_wr_o       (btb_wr),
    .ibtc_wr_o      (ibtc_wr)
  );

  gshare_pht u_pht (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_pc_i   (fetch_dec.pc),
    .train_en_i    (pht_train_en),
    .train_pc_i    (resolve_i.pc),
    .train_taken_i (resolve_i.taken),
    .taken_o       (pht_taken)
  );

  // Conditional branch targets
  target_cache #(.ENTRIES(`BP_BTB_ENTRIES)) u_btb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lookup_pc_i (fetch_dec.pc),
    .wr_i        (btb_wr),
    .hit_o       (btb_hit),
    .target_o    (btb_target)
  );

  // JALR targets
  target_cache #(.ENTRIES(`BP_IBTC_ENTRIES)) u_ibtc (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lookup_pc_i (fetch_dec.pc),
    .wr_i        (ibtc_wr),
    .hit_o       (ibtc_hit),
    .target_o    (ibtc_target)
  );

  predict_select u_select (
    .fetch_dec_i   (fetch_dec),
    .pht_taken_i   (pht_taken),
    .btb_hit_i     (btb_hit),
    .btb_target_i  (btb_target),
    .ibtc_hit_i    (ibtc_hit),
    .ibtc_target_i (ibtc_target),
    .pred_o        (pred_o)
  );

endmodule

/* test/tb_bp_tasks.svh */
// ==========================================================
// Stimulus tasks for the branch predictor testbench
// Included into the testbench module body
// ==========================================================

`ifndef TB_BP_TASKS_SVH
`define TB_BP_TASKS_SVH

// RV32I encodings carrying the chosen immediate
function automatic logic [31:0] encode(input cti_kind_e kind, input xaddr_t imm);
  case (kind)
    CTI_BRANCH: return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    CTI_JAL:    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    CTI_JALR:   return {imm[11:0], 5'd5, 3'b000, 5'd1, 7'b1100111};
    // Plain addi, no transfer
    default:    return 32'h0000_0013;
  endcase
endfunction

task automatic stage_fetch(input cti_kind_e kind, input xaddr_t pc, input xaddr_t imm);
  nx_fetch.valid = 1'b1;
  nx_fetch.pc    = pc;
  nx_fetch.instr = encode(kind, imm);
  nx_kind        = kind;
  nx_imm         = imm;
endtask

task automatic stage_resolve(input cti_kind_e kind, input xaddr_t pc, input logic taken,
                             input xaddr_t target);
  nx_resolve = {1'b1, kind, pc, taken, target};
endtask

// Staged inputs go out on the falling edge, then fall back to idle
task automatic cycle(input logic stl);
  @(negedge clk);
  fetch    = nx_fetch;
  resolve  = nx_resolve;
  stall    = stl;
  cur_kind = nx_kind;
  cur_imm  = nx_imm;
  exp_pred = expect_pred();
  nx_fetch   = '0;
  nx_resolve = '0;
  nx_kind    = CTI_NONE;
  nx_imm     = '0;
endtask

// One resolve, then a fetch of the same branch
task automatic train_pair(input xaddr_t pc, input xaddr_t target, input logic taken);
  stage_resolve(CTI_BRANCH, pc, taken, target);
  cycle(1'b0);
  stage_fetch(CTI_BRANCH, pc, 32'h0000_0020);
  cycle(1'b0);
endtask

task automatic train_until(input xaddr_t pc, input xaddr_t target, input logic taken,
                           input int limit, input int extra);
  int n;
  bit done;
  n    = 0;
  done = 1'b0;
  while (!done && n < limit) begin
    train_pair(pc, target, taken);
    // Counter that the next fetch of this pc reads
    done = (m_pht[pht_index(pc)][1] == taken);
    n++;
  end
  if (!done) begin
    timeouts++;
    $display("Timeout at %0t: counter for pc %h did not turn %s within %0d resolves",
             $time, pc, taken ? "taken" : "not-taken", limit);
  end
  // Push on into saturation
  repeat (extra) train_pair(pc, target, taken);
endtask

`endif

/* test/tb_bp_top.sv */
// ==========================================================
// Testbench of the fetch-stage branch predictor
// Reference model of history, counters and target caches
// ==========================================================
`timescale 1ns/1ps
`include "bp_config.svh"

module tb_bp_top;
  import bp_pkg::*;

  localparam int PHT_IDX_W = $clog2(`BP_PHT_ENTRIES);
  localparam int GHR_W     = `BP_GHR_BITS;

  logic      clk;
  logic      rst_n;
  logic      stall;
  fetch_t    fetch;
  resolve_t  resolve;
  pred_t     pred;
  pred_t     exp_pred;
  // Next-cycle stimulus
  fetch_t    nx_fetch;
  resolve_t  nx_resolve;
  cti_kind_e nx_kind;
  cti_kind_e cur_kind;
  xaddr_t    nx_imm;
  xaddr_t    cur_imm;

  // ==========================================================
  // Reference model
  // ==========================================================

  logic [GHR_W-1:0] m_ghr;
  logic [1:0]       m_pht [`BP_PHT_ENTRIES];
  // Keyed by the full word-aligned PC
  xaddr_t           m_btb [xaddr_t];
  xaddr_t           m_ibtc [xaddr_t];

  integer seed;
  int     pc_errs;
  int     taken_errs;
  int     src_errs;
  int     timeouts;

  function automatic logic [PHT_IDX_W-1:0] pht_index(input xaddr_t pc);
    return pc[PHT_IDX_W+1:2] ^ PHT_IDX_W'(m_ghr);
  endfunction

  // Direct-mapped set from PC bit 2
  function automatic bit same_set(input xaddr_t a, input xaddr_t b, input int entries);
    return ((a >> 2) % xaddr_t'(entries)) == ((b >> 2) % xaddr_t'(entries));
  endfunction

  // A write evicts whatever shares the set
  task automatic cache_write(input bit is_btb, input xaddr_t pc, input xaddr_t target);
    xaddr_t victims[$];
    if (is_btb) begin
      foreach (m_btb[k]) begin
        if (same_set(k, pc, `BP_BTB_ENTRIES)) victims.push_back(k);
      end
      foreach (victims[i]) m_btb.delete(victims[i]);
      m_btb[pc] = target;
    end else begin
      foreach (m_ibtc[k]) begin
        if (same_set(k, pc, `BP_IBTC_ENTRIES)) victims.push_back(k);
      end
      foreach (victims[i]) m_ibtc.delete(victims[i]);
      m_ibtc[pc] = target;
    end
  endtask

  task automatic train_model();
    logic [PHT_IDX_W-1:0] idx;
    logic [1:0]           ctr;
    if (resolve.kind == CTI_BRANCH) begin
      // Index from the history before the shift
      idx = pht_index(resolve.pc);
      ctr = m_pht[idx];
      if (resolve.taken && ctr != 2'b11) ctr = ctr + 2'd1;
      else if (!resolve.taken && ctr != 2'b00) ctr = ctr - 2'd1;
      m_pht[idx] = ctr;
      m_ghr = {m_ghr[GHR_W-2:0], resolve.taken};
      if (resolve.taken) cache_write(1'b1, resolve.pc, resolve.target);
    end else if (resolve.kind == CTI_JALR) begin
      cache_write(1'b0, resolve.pc, resolve.target);
    end
  endtask

  // JAL, JALR on IBTC hit, taken branch on BTB hit, else pc+4
  function automatic pred_t expect_pred();
    pred_t  p;
    xaddr_t pc;
    pc      = fetch.pc;
    p.pc    = pc + 32'd4;
    p.taken = 1'b0;
    p.src   = SRC_SEQ;
    if (fetch.valid && !stall) begin
      if (cur_kind == CTI_JAL) begin
        p = {pc + cur_imm, 1'b1, SRC_JUMP};
      end else if (cur_kind == CTI_JALR && m_ibtc.exists(pc)) begin
        p = {m_ibtc[pc], 1'b1, SRC_JUMP};
      end else if (cur_kind == CTI_BRANCH && m_pht[pht_index(pc)][1] && m_btb.exists(pc)) begin
        p = {m_btb[pc], 1'b1, SRC_BRANCH};
      end
    end
    return p;
  endfunction

  function automatic xaddr_t rand_pc();
    logic [31:0] r;
    r = $random(seed);
    // 128 words, so BTB and IBTC sets alias
    return 32'h0000_4000 | {23'd0, r[6:0], 2'b00};
  endfunction

  function automatic xaddr_t rand_imm(input cti_kind_e kind);
    logic [31:0] r;
    r = $random(seed);
    if (kind == CTI_BRANCH) return {{19{r[12]}}, r[12:1], 1'b0};
    if (kind == CTI_JAL) return {{11{r[20]}}, r[20:1], 1'b0};
    return {{20{r[11]}}, r[11:0]};
  endfunction

  `include "tb_bp_tasks.svh"

  // ==========================================================
  // Clock, DUT, model update, checks
  // ==========================================================

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  bp_top dut0 (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .stall_i   (stall),
    .fetch_i   (fetch),
    .resolve_i (resolve),
    .pred_o    (pred)
  );

  always @(posedge clk) begin
    if (rst_n && resolve.valid && !stall) train_model();
  end

  a_pred_pc: assert property (@(posedge clk) disable iff (!rst_n) pred.pc == exp_pred.pc)
    else begin
      pc_errs++;
      $display("Error at %0t: pred_o.pc expected %h, got %h",
               $time, $sampled(exp_pred.pc), $sampled(pred.pc));
    end

  a_pred_taken: assert property (@(posedge clk) disable iff (!rst_n)
                                 pred.taken == exp_pred.taken)
    else begin
      taken_errs++;
      $display("Error at %0t: pred_o.taken expected %b, got %b",
               $time, $sampled(exp_pred.taken), $sampled(pred.taken));
    end

  a_pred_src: assert property (@(posedge clk) disable iff (!rst_n) pred.src == exp_pred.src)
    else begin
      src_errs++;
      $display("Error at %0t: pred_o.src expected %0d, got %0d",
               $time, $sampled(exp_pred.src), $sampled(pred.src));
    end

  // ==========================================================
  // Test sequence
  // ==========================================================

  initial begin
    logic [31:0] r;
    cti_kind_e   k;
    seed       = 32'he276;
    pc_errs    = 0;
    taken_errs = 0;
    src_errs   = 0;
    timeouts   = 0;
    rst_n      = 1'b0;
    stall      = 1'b0;
    fetch      = '0;
    resolve    = '0;
    nx_fetch   = '0;
    nx_resolve = '0;
    nx_kind    = CTI_NONE;
    cur_kind   = CTI_NONE;
    nx_imm     = '0;
    cur_imm    = '0;
    m_ghr      = '0;
    foreach (m_pht[i]) m_pht[i] = 2'b01;
    exp_pred   = expect_pred();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Cold tables
    stage_fetch(CTI_BRANCH, 32'h0000_4100, 32'h0000_0040);
    cycle(1'b0);
    stage_fetch(CTI_JALR, 32'h0000_4104, '0);
    cycle(1'b0);
    // JAL at both ends of the offset range
    stage_fetch(CTI_JAL, 32'h0000_4200, 32'hFFF0_0000);
    cycle(1'b0);
    stage_fetch(CTI_JAL, 32'h0000_4204, 32'h000F_FFFE);
    cycle(1'b0);
    // JALR hit, then same set with another tag
    stage_resolve(CTI_JALR, 32'h0000_4300, 1'b1, 32'h0000_8800);
    cycle(1'b0);
    stage_fetch(CTI_JALR, 32'h0000_4300, '0);
    cycle(1'b0);
    stage_fetch(CTI_JALR, 32'h0000_4300 + (`BP_IBTC_ENTRIES * 4), '0);
    cycle(1'b0);
    // Counter up to taken and saturated, then back down
    train_until(32'h0000_4400, 32'h0000_4040, 1'b1, 32, 12);
    train_until(32'h0000_4400, 32'h0000_4040, 1'b0, 32, 12);
    // Stalled fetch and lost resolves
    stage_fetch(CTI_JAL, 32'h0000_4500, 32'h0000_0100);
    stage_resolve(CTI_JALR, 32'h0000_4504, 1'b1, 32'h0000_9000);
    cycle(1'b1);
    stage_resolve(CTI_BRANCH, 32'h0000_4400, 1'b1, 32'h0000_4040);
    cycle(1'b1);
    stage_fetch(CTI_JALR, 32'h0000_4504, '0);
    cycle(1'b0);
    stage_fetch(CTI_BRANCH, 32'h0000_4400, 32'h0000_0010);
    cycle(1'b0);

    // Mixed random traffic
    for (int i = 0; i < 1500; i++) begin
      r = $random(seed);
      k = cti_kind_e'(r[12:11]);
      if (r[5:3] != 3'd0) stage_fetch(k, rand_pc(), rand_imm(k));
      if (r[6]) stage_resolve(cti_kind_e'(r[8:7]), rand_pc(), r[10:9] != 2'b00, rand_pc());
      cycle(r[2:0] == 3'd0);
    end
    cycle(1'b0);
    @(negedge clk);

    $display("Errors: pred_o.pc %0d, pred_o.taken %0d, pred_o.src %0d, timeouts %0d",
             pc_errs, taken_errs, src_errs, timeouts);
    if (pc_errs + taken_errs + src_errs + timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+common
+incdir+test
common/bp_pkg.sv
rtl/bp_decode.sv
predictor/gshare_pht.sv
predictor/target_cache.sv
rtl/predict_select.sv
rtl/bp_top.sv
test/tb_bp_top.sv

/* Makefile */
# Verilator build and run of the branch predictor testbench

TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_bp_top
FLIST = src.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG) || ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
